/* filelist.f */
hdl/kt11_pkg.sv
hdl/page_reg_file.sv
hdl/addr_relocator.sv
hdl/access_checker.sv
hdl/mmu_status_regs.sv
hdl/kt11_mmu.sv
test/kt11_mmu_tb.sv

/* Bender.yml */
package:
  name: kt11_mmu

sources:
  - hdl/kt11_pkg.sv
  - hdl/page_reg_file.sv
  - hdl/addr_relocator.sv
  - hdl/access_checker.sv
  - hdl/mmu_status_regs.sv
  - hdl/kt11_mmu.sv
  - target: simulation
    files:
      - test/kt11_mmu_tb.sv

/* test/kt11_mmu_tb.sv */
// ==================================================
// KT-11 MMU testbench
// random host and CPU traffic against a reference model
// ==================================================
`timescale 1ns/1ps

module kt11_mmu_tb;

   localparam int cycle_limit = 4000;

   logic        clk;
   logic        local_reset;
   logic [15:0] cpu_va;
   logic [1:0]  cpu_cm;
   logic        cpu_rd;
   logic        cpu_wr;
   logic        cpu_i_access;
   logic        cpu_d_access;
   logic        cpu_trap;
   logic        fetch_va;
   logic        trap_odd;
   logic [21:0] cpu_pa;
   logic        signal_abort;
   logic        signal_trap;
   logic        pxr_wr;
   logic        pxr_rd;
   logic [1:0]  pxr_be;
   logic [7:0]  pxr_addr;
   logic [15:0] pxr_data_in;
   logic [15:0] pxr_data_out;

   // reference copies of the MMU registers
   logic [15:0] par_m [64];
   logic [15:0] pdr_m [64];
   logic [15:0] mmr0_m;
   logic [15:0] mmr2_m;
   logic [15:0] mmr3_m;

   integer seed = 32'h586ae168;
   integer errors = 0;
   integer checks = 0;
   integer cycles = 0;

   kt11_mmu #(
      .map_22bit (1'b0)
   ) kt11_mmu_i (
      .clk          (clk),
      .local_reset  (local_reset),
      .cpu_va       (cpu_va),
      .cpu_cm       (cpu_cm),
      .cpu_rd       (cpu_rd),
      .cpu_wr       (cpu_wr),
      .cpu_i_access (cpu_i_access),
      .cpu_d_access (cpu_d_access),
      .cpu_trap     (cpu_trap),
      .fetch_va     (fetch_va),
      .trap_odd     (trap_odd),
      .cpu_pa       (cpu_pa),
      .signal_abort (signal_abort),
      .signal_trap  (signal_trap),
      .pxr_wr       (pxr_wr),
      .pxr_rd       (pxr_rd),
      .pxr_be       (pxr_be),
      .pxr_addr     (pxr_addr),
      .pxr_data_in  (pxr_data_in),
      .pxr_data_out (pxr_data_out)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout: the run reached %0d cycles before all tests ended", cycle_limit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] exp_val);
      checks = checks + 1;
      if (got !== exp_val)
      begin
         errors = errors + 1;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp_val);
      end
   endtask

   // {mode, d space, apf}, trap vectors go through kernel space
   function automatic logic [5:0] page_of(input logic [15:0] va, input logic [1:0] cm,
      input logic trap, input logic i_acc);
      logic       split;
      logic [1:0] mode;
      split = (cm == kt11_pkg::mode_kernel) ? mmr3_m[2] :
              (cm == kt11_pkg::mode_super)  ? mmr3_m[1] :
              (cm == kt11_pkg::mode_user)   ? mmr3_m[0] : 1'b0;
      mode = trap ? kt11_pkg::mode_kernel : cm;
      return {mode, split & ~i_acc, va[15:13]};
   endfunction

   // 18 bit relocation, top 8k folded onto the 22 bit I/O page
   function automatic logic [21:0] pa_of(input logic [15:0] va, input logic [15:0] par);
      logic [21:0] pa;
      pa = ({10'd0, par[11:0]} << 6) + {9'd0, va[12:0]};
      pa = pa & 22'h03ffff;
      if (pa[17:13] == 5'h1f)
         pa = pa | 22'h3f0000;
      return pa;
   endfunction

   function automatic logic [7:0] rand_reg_addr();
      logic [31:0] r;
      r = $random(seed);
      if (r[9:8] == 2'b00)
         return {6'b100000, r[1:0]};
      return {1'b0, r[6:0]};
   endfunction

   task automatic drive_idle();
      cpu_va       = 16'h0000;
      cpu_cm       = kt11_pkg::mode_kernel;
      cpu_rd       = 1'b0;
      cpu_wr       = 1'b0;
      cpu_i_access = 1'b0;
      cpu_d_access = 1'b0;
      cpu_trap     = 1'b0;
      fetch_va     = 1'b0;
      trap_odd     = 1'b0;
      pxr_wr       = 1'b0;
      pxr_rd       = 1'b0;
      pxr_be       = 2'b00;
      pxr_addr     = 8'h00;
      pxr_data_in  = 16'h0000;
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
      drive_idle();
   endtask

   // compare outputs mid cycle, then advance the model to the next edge
   task automatic eval_cycle();
      logic [5:0]  idx;
      logic [15:0] pdr;
      logic [21:0] exp_pa;
      logic [15:0] exp_out;
      logic        on;
      logic        held;
      logic        len_err;
      logic        access;
      logic        abort;
      logic        trap;
      logic        upd;
      logic        sa;
      logic        sw;
      logic [2:0]  flags;
      @(negedge clk);
      on      = mmr0_m[0];
      held    = |mmr0_m[15:13];
      idx     = page_of(cpu_va, cpu_cm, cpu_trap, cpu_i_access);
      pdr     = pdr_m[idx] & kt11_pkg::pdr_read_mask;
      if (on || (mmr0_m[8] && cpu_d_access))
         exp_pa = pa_of(cpu_va, par_m[idx]);
      else
         exp_pa = (cpu_va[15:13] == 3'b111) ? {6'h3f, cpu_va} : {6'h00, cpu_va};
      len_err = pdr[3] ? (cpu_va[12:6] < pdr[14:8]) : (cpu_va[12:6] > pdr[14:8]);
      access  = on && (cpu_rd || cpu_wr);
      abort   = 1'b0;
      trap    = 1'b0;
      upd     = 1'b0;
      sa      = 1'b0;
      sw      = 1'b0;
      // flags are nonres, ple, ro
      flags   = 3'b000;
      if (access && cpu_cm == kt11_pkg::mode_super)
      begin
         abort = 1'b1;
         flags = 3'b100;
      end
      else if (access && cpu_wr)
      begin
         upd = 1'b1;
         case (pdr[2:0])
            kt11_pkg::acf_nonres:
            begin
               abort = 1'b1;
               flags = {1'b1, len_err, 1'b0};
            end
            kt11_pkg::acf_read_only:
            begin
               abort = 1'b1;
               flags = {1'b0, len_err, 1'b1};
            end
            kt11_pkg::acf_read_write:
            begin
               trap  = 1'b1;
               flags = 3'b100;
               sa    = 1'b1;
            end
            default:
            begin
               sw    = !trap_odd;
               trap  = len_err;
               flags = {1'b0, len_err, 1'b0};
            end
         endcase
      end
      else if (access)
      begin
         case (pdr[2:0])
            kt11_pkg::acf_nonres:
            begin
               abort = 1'b1;
               flags = {1'b1, len_err, 1'b0};
            end
            kt11_pkg::acf_read_write:
            begin
               trap  = 1'b1;
               flags = 3'b100;
               upd   = 1'b1;
               sa    = 1'b1;
            end
            default:
            begin
               abort = len_err;
               flags = {1'b0, len_err, 1'b0};
            end
         endcase
      end
      exp_out = 16'h0000;
      if (pxr_rd && pxr_addr[7])
      begin
         case (pxr_addr[1:0])
            2'd0:
            begin
               exp_out = mmr0_m;
               // live mode and page unless frozen or unmapped
               if (on && !held)
               begin
                  exp_out[6:5] = cpu_cm;
                  exp_out[3:1] = cpu_va[15:13];
               end
            end
            2'd2:    exp_out = mmr2_m;
            2'd3:    exp_out = mmr3_m;
            default: exp_out = 16'h0000;
         endcase
      end
      else if (pxr_rd && pxr_addr[6])
         exp_out = par_m[pxr_addr[5:0]] & kt11_pkg::par_mask;
      else if (pxr_rd)
         exp_out = pdr_m[pxr_addr[5:0]] & kt11_pkg::pdr_read_mask;
      check_value("cpu_pa", cpu_pa, exp_pa);
      check_value("signal_abort", signal_abort, abort);
      check_value("signal_trap", signal_trap, trap);
      check_value("pxr_data_out", pxr_data_out, exp_out);
      // host write takes priority over hardware updates
      if (pxr_wr && pxr_addr[7] && pxr_addr[1:0] == 2'd0)
      begin
         if (pxr_be[1])
            mmr0_m[15:8] = pxr_data_in[15:8];
         if (pxr_be[0])
            mmr0_m[7:0] = pxr_data_in[7:0];
      end
      else if (pxr_wr && pxr_addr[7] && pxr_addr[1:0] == 2'd3)
         mmr3_m = pxr_data_in;
      else if (pxr_wr && !pxr_addr[7] && pxr_addr[6])
      begin
         if (pxr_be[1])
            par_m[pxr_addr[5:0]][15:8] = pxr_data_in[15:8];
         if (pxr_be[0])
            par_m[pxr_addr[5:0]][7:0] = pxr_data_in[7:0];
      end
      else if (pxr_wr && !pxr_addr[7])
      begin
         if (pxr_be[1])
            pdr_m[pxr_addr[5:0]][15:8] = pxr_data_in[15:8] & 8'o177;
         if (pxr_be[0])
            pdr_m[pxr_addr[5:0]][7:0] = pxr_data_in[7:0] & 8'o016;
      end
      else if (!pxr_wr)
      begin
         if (upd)
            pdr_m[idx] = pdr | {8'h00, sa, sw, 6'b000000};
         if (on && !held)
         begin
            mmr0_m[15:13] = mmr0_m[15:13] | flags;
            if (access)
            begin
               mmr0_m[6:5] = cpu_cm;
               mmr0_m[3:1] = cpu_va[15:13];
            end
         end
      end
      if (fetch_va && !held && cpu_cm != kt11_pkg::mode_super)
         mmr2_m = cpu_va;
   endtask

   task automatic host_write(input logic [7:0] addr, input logic [1:0] be,
      input logic [15:0] data);
      next_cycle();
      pxr_wr      = 1'b1;
      pxr_addr    = addr;
      pxr_be      = be;
      pxr_data_in = data;
      eval_cycle();
   endtask

   task automatic host_read(input logic [7:0] addr);
      next_cycle();
      pxr_rd   = 1'b1;
      pxr_addr = addr;
      eval_cycle();
   endtask

   initial
   begin
      integer      i;
      logic [31:0] r;
      logic [15:0] va;
      logic [1:0]  cm;
      logic [5:0]  idx;
      drive_idle();
      local_reset = 1'b1;
      mmr0_m = 16'h0000;
      mmr2_m = 16'h0000;
      mmr3_m = 16'h0000;
      repeat (16) @(posedge clk);
      #2;
      local_reset = 1'b0;

      // page registers are not reset, load them all first
      for (i = 0; i < 64; i++)
      begin
         host_write({2'b01, i[5:0]}, 2'b11, $random(seed));
         host_write({2'b00, i[5:0]}, 2'b11, $random(seed));
      end

      // register access with random byte enables
      for (i = 0; i < 300; i++)
      begin
         r = $random(seed);
         if (r[0])
            host_write(rand_reg_addr(), r[2:1], $random(seed));
         else
            host_read(rand_reg_addr());
      end
      host_write(8'h80, 2'b11, 16'h0000);

      // mapping off, maint mode maps destination accesses
      for (i = 0; i < 150; i++)
      begin
         r = $random(seed);
         if (r[3:0] == 4'd0)
            host_write(8'h80, 2'b11, r[4] ? 16'h0100 : 16'h0000);
         next_cycle();
         cpu_va       = $random(seed);
         cpu_cm       = r[6:5];
         cpu_d_access = r[7];
         cpu_i_access = !r[7];
         cpu_rd       = r[8];
         cpu_wr       = r[9] && !r[8];
         cpu_trap     = r[10];
         eval_cycle();
      end

      // mapping on, relocation without access strobes
      host_write(8'h80, 2'b11, 16'h0001);
      host_write(8'h83, 2'b11, $random(seed));
      for (i = 0; i < 300; i++)
      begin
         r = $random(seed);
         if (r[3:0] == 4'd0)
            host_write(r[4] ? 8'h83 : {2'b01, r[13:8]}, 2'b11, $random(seed));
         next_cycle();
         cpu_va       = $random(seed);
         cpu_cm       = r[6:5];
         cpu_trap     = r[7];
         cpu_i_access = r[14];
         cpu_d_access = !r[14];
         eval_cycle();
      end

      // access control on one freshly written PDR per round
      for (i = 0; i < 250; i++)
      begin
         r   = $random(seed);
         va  = $random(seed);
         cm  = r[0] ? kt11_pkg::mode_user : kt11_pkg::mode_kernel;
         if (r[7:6] == 2'b00)
            host_write(8'h83, 2'b11, $random(seed));
         idx = page_of(va, cm, r[1], r[2]);
         host_write(8'h80, 2'b11, 16'h0001);
         host_write({2'b00, idx}, 2'b11, $random(seed));
         next_cycle();
         cpu_va       = va;
         cpu_cm       = cm;
         cpu_trap     = r[1];
         cpu_i_access = r[2];
         cpu_d_access = !r[2];
         cpu_wr       = r[3];
         cpu_rd       = !r[3];
         trap_odd     = r[4];
         eval_cycle();
         host_read({2'b00, idx});
         if (r[5])
         begin
            // low byte write drops A and W
            host_write({2'b00, idx}, 2'b01, $random(seed));
            host_read({2'b00, idx});
         end
      end

      // fault latching, mmr2 tracking, supervisor aborts
      host_write(8'h80, 2'b11, 16'h0001);
      for (i = 0; i < 300; i++)
      begin
         r = $random(seed);
         if (r[4:0] == 5'd0)
            host_write(8'h80, 2'b11, 16'h0001);
         next_cycle();
         cpu_va       = $random(seed);
         cpu_cm       = (r[6:5] == 2'b10) ? kt11_pkg::mode_user : r[6:5];
         cpu_rd       = r[7];
         cpu_wr       = r[8] && !r[7];
         fetch_va     = r[9];
         cpu_i_access = r[9];
         cpu_d_access = !r[9];
         trap_odd     = r[10];
         pxr_rd       = r[11];
         pxr_addr     = {6'b100000, r[13:12]};
         eval_cycle();
      end

      next_cycle();
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

/* hdl/kt11_mmu.sv */
// ==================================================
// KT-11 memory management unit, 11/34 flavour
// ==================================================
`timescale 1ns/1ps

module kt11_mmu #(
   parameter bit map_22bit = 1'b0
) (
   input  logic                          clk,
   input  logic                          local_reset,
   input  logic [kt11_pkg::va_width-1:0] cpu_va,
   input  logic [1:0]                    cpu_cm,
   input  logic                          cpu_rd,
   input  logic                          cpu_wr,
   input  logic                          cpu_i_access,
   input  logic                          cpu_d_access,
   input  logic                          cpu_trap,
   input  logic                          fetch_va,
   input  logic                          trap_odd,
   output logic [kt11_pkg::pa_width-1:0] cpu_pa,
   output logic                          signal_abort,
   output logic                          signal_trap,
   input  logic                          pxr_wr,
   input  logic                          pxr_rd,
   input  logic [1:0]                    pxr_be,
   input  logic [7:0]                    pxr_addr,
   input  logic [15:0]                   pxr_data_in,
   output logic [15:0]                   pxr_data_out
);

   logic [5:0]  page_index;
   logic [15:0] lookup_par;
   logic [15:0] lookup_pdr;
   logic [15:0] host_read_data;
   logic        pdr_update;
   logic        set_a;
   logic        set_w;
   logic        flag_nonres;
   logic        flag_ple;
   logic        flag_ro;
   logic        record_page;
   logic        mmu_on;
   logic        maint_mode;

   page_reg_file page_reg_file_i (
      .clk            (clk),
      .local_reset    (local_reset),
      .pxr_wr         (pxr_wr),
      .pxr_rd         (pxr_rd),
      .pxr_be         (pxr_be),
      .pxr_addr       (pxr_addr),
      .pxr_data_in    (pxr_data_in),
      .page_index     (page_index),
      .pdr_update     (pdr_update),
      .set_a          (set_a),
      .set_w          (set_w),
      .lookup_par     (lookup_par),
      .lookup_pdr     (lookup_pdr),
      .host_read_data (host_read_data)
   );

   addr_relocator #(
      .map_22bit (map_22bit)
   ) addr_relocator_i (
      .cpu_va       (cpu_va),
      .cpu_d_access (cpu_d_access),
      .lookup_par   (lookup_par),
      .mmu_on       (mmu_on),
      .maint_mode   (maint_mode),
      .cpu_pa       (cpu_pa)
   );

   access_checker access_checker_i (
      .cpu_va       (cpu_va),
      .cpu_cm       (cpu_cm),
      .cpu_rd       (cpu_rd),
      .cpu_wr       (cpu_wr),
      .trap_odd     (trap_odd),
      .lookup_pdr   (lookup_pdr),
      .mmu_on       (mmu_on),
      .signal_abort (signal_abort),
      .signal_trap  (signal_trap),
      .pdr_update   (pdr_update),
      .set_a        (set_a),
      .set_w        (set_w),
      .flag_nonres  (flag_nonres),
      .flag_ple     (flag_ple),
      .flag_ro      (flag_ro),
      .record_page  (record_page)
   );

   mmu_status_regs mmu_status_regs_i (
      .clk            (clk),
      .local_reset    (local_reset),
      .cpu_va         (cpu_va),
      .cpu_cm         (cpu_cm),
      .cpu_i_access   (cpu_i_access),
      .cpu_trap       (cpu_trap),
      .fetch_va       (fetch_va),
      .pxr_wr         (pxr_wr),
      .pxr_rd         (pxr_rd),
      .pxr_be         (pxr_be),
      .pxr_addr       (pxr_addr),
      .pxr_data_in    (pxr_data_in),
      .host_read_data (host_read_data),
      .flag_nonres    (flag_nonres),
      .flag_ple       (flag_ple),
      .flag_ro        (flag_ro),
      .record_page    (record_page),
      .page_index     (page_index),
      .mmu_on         (mmu_on),
      .maint_mode     (maint_mode),
      .pxr_data_out   (pxr_data_out)
   );

endmodule

/* hdl/mmu_status_regs.sv */
// ==================================================
// KT-11 status registers
// mmr0/2/3, fault latch, page index, host read mux
// ==================================================
`timescale 1ns/1ps

module mmu_status_regs (
   input  logic                          clk,
   input  logic                          local_reset,
   input  logic [kt11_pkg::va_width-1:0] cpu_va,
   input  logic [1:0]                    cpu_cm,
   input  logic                          cpu_i_access,
   input  logic                          cpu_trap,
   input  logic                          fetch_va,
   input  logic                          pxr_wr,
   input  logic                          pxr_rd,
   input  logic [1:0]                    pxr_be,
   input  logic [7:0]                    pxr_addr,
   input  logic [15:0]                   pxr_data_in,
   input  logic [15:0]                   host_read_data,
   input  logic                          flag_nonres,
   input  logic                          flag_ple,
   input  logic                          flag_ro,
   input  logic                          record_page,
   output logic [5:0]                    page_index,
   output logic                          mmu_on,
   output logic                          maint_mode,
   output logic [15:0]                   pxr_data_out
);

   logic [15:0] mmr0;
   logic [15:0] mmr2;
   logic [15:0] mmr3;
   logic [15:0] mmr0_live;
   logic [2:0]  fault_bits;
   logic        fault_held;
   logic        mmr0_wr;
   logic        mmr3_wr;
   logic        d_space;

   assign mmu_on     = mmr0[kt11_pkg::mmr0_enable];
   assign maint_mode = mmr0[kt11_pkg::mmr0_maint];
   assign fault_bits = mmr0[kt11_pkg::mmr0_nonres:kt11_pkg::mmr0_ro];
   assign fault_held = |fault_bits;

   assign mmr0_wr = pxr_wr && pxr_addr[7] && (pxr_addr[1:0] == 2'd0);
   assign mmr3_wr = pxr_wr && pxr_addr[7] && (pxr_addr[1:0] == 2'd3);

   // split I/D enable per mode
   always_comb
   begin
      case (cpu_cm)
         kt11_pkg::mode_kernel: d_space = mmr3[2];
         kt11_pkg::mode_super:  d_space = mmr3[1];
         kt11_pkg::mode_user:   d_space = mmr3[0];
         default:               d_space = 1'b0;
      endcase
   end

   // trap vectors are always fetched through kernel space
   assign page_index = {cpu_trap ? kt11_pkg::mode_kernel : cpu_cm,
                        d_space & ~cpu_i_access, cpu_va[15:13]};

   always_ff @(posedge clk or posedge local_reset)
   begin
      if (local_reset)
      begin
         mmr0 <= '0;
         mmr3 <= '0;
      end
      else if (pxr_wr)
      begin
         if (mmr0_wr && pxr_be[1])
            mmr0[15:8] <= pxr_data_in[15:8];
         if (mmr0_wr && pxr_be[0])
            mmr0[7:0] <= pxr_data_in[7:0];
         if (mmr3_wr)
            mmr3 <= pxr_data_in;
      end
      else if (mmu_on && !fault_held)
      begin
         if (flag_nonres)
            mmr0[kt11_pkg::mmr0_nonres] <= 1'b1;
         if (flag_ple)
            mmr0[kt11_pkg::mmr0_ple] <= 1'b1;
         if (flag_ro)
            mmr0[kt11_pkg::mmr0_ro] <= 1'b1;
         if (record_page)
         begin
            mmr0[kt11_pkg::mmr0_mode_hi:kt11_pkg::mmr0_mode_lo] <= cpu_cm;
            mmr0[kt11_pkg::mmr0_page_hi:kt11_pkg::mmr0_page_lo] <= cpu_va[15:13];
         end
      end
   end

   // mmr2 tracks instruction fetches until something goes wrong
   always_ff @(posedge clk or posedge local_reset)
   begin
      if (local_reset)
         mmr2 <= '0;
      else if (fetch_va && !fault_held && cpu_cm != kt11_pkg::mode_super)
         mmr2 <= cpu_va;
   end

   always_comb
   begin
      mmr0_live = mmr0;
      mmr0_live[kt11_pkg::mmr0_mode_hi:kt11_pkg::mmr0_mode_lo] = cpu_cm;
      mmr0_live[kt11_pkg::mmr0_page_hi:kt11_pkg::mmr0_page_lo] = cpu_va[15:13];
      pxr_data_out = '0;
      if (pxr_rd && pxr_addr[7])
      begin
         case (pxr_addr[1:0])
            2'd0:    pxr_data_out = (fault_held || !mmu_on) ? mmr0 : mmr0_live;
            2'd2:    pxr_data_out = mmr2;
            2'd3:    pxr_data_out = mmr3;
            // mmr1 not implemented
            default: pxr_data_out = '0;
         endcase
      end
      else if (pxr_rd)
         pxr_data_out = host_read_data;
   end

   // latched fault flags only go away through the host
   fault_sticky: assert property (@(posedge clk) disable iff (local_reset)
      !mmr0_wr |=> (($past(fault_bits) & ~fault_bits) == 3'b000));

endmodule

/* hdl/access_checker.sv */
// ==================================================
// KT-11 access checker
// acf and page length rules, abort/trap, A/W bits
// ==================================================
`timescale 1ns/1ps

module access_checker (
   input  logic [kt11_pkg::va_width-1:0] cpu_va,
   input  logic [1:0]                    cpu_cm,
   input  logic                          cpu_rd,
   input  logic                          cpu_wr,
   input  logic                          trap_odd,
   input  logic [15:0]                   lookup_pdr,
   input  logic                          mmu_on,
   output logic                          signal_abort,
   output logic                          signal_trap,
   output logic                          pdr_update,
   output logic                          set_a,
   output logic                          set_w,
   output logic                          flag_nonres,
   output logic                          flag_ple,
   output logic                          flag_ro,
   output logic                          record_page
);

   logic [6:0] block_num;
   logic [6:0] page_len;
   logic       expand_down;
   logic [2:0] acf;
   logic       pg_len_err;

   assign block_num   = cpu_va[12:6];
   assign page_len    = lookup_pdr[14:8];
   assign expand_down = lookup_pdr[3];
   assign acf         = lookup_pdr[2:0];

   // downward pages grow from the top of the 8k window
   assign pg_len_err = expand_down ? (block_num < page_len) : (block_num > page_len);

   always_comb
   begin
      signal_abort = 1'b0;
      signal_trap  = 1'b0;
      pdr_update   = 1'b0;
      set_a        = 1'b0;
      set_w        = 1'b0;
      flag_nonres  = 1'b0;
      flag_ple     = 1'b0;
      flag_ro      = 1'b0;
      record_page  = 1'b0;

      // 11/34 has no supervisor space
      if (mmu_on && (cpu_rd || cpu_wr) && cpu_cm == kt11_pkg::mode_super)
      begin
         signal_abort = 1'b1;
         flag_nonres  = 1'b1;
         record_page  = 1'b1;
      end
      else if (mmu_on && cpu_wr)
      begin
         record_page = 1'b1;
         pdr_update  = 1'b1;
         case (acf)
            kt11_pkg::acf_nonres:
            begin
               signal_abort = 1'b1;
               flag_nonres  = 1'b1;
               flag_ple     = pg_len_err;
            end
            kt11_pkg::acf_read_only:
            begin
               signal_abort = 1'b1;
               flag_ro      = 1'b1;
               flag_ple     = pg_len_err;
            end
            kt11_pkg::acf_read_write:
            begin
               signal_trap = 1'b1;
               flag_nonres = 1'b1;
               set_a       = 1'b1;
            end
            kt11_pkg::acf_rw_ok:
            begin
               set_w       = !trap_odd;
               signal_trap = pg_len_err;
               flag_ple    = pg_len_err;
            end
            default: ;
         endcase
      end
      else if (mmu_on && cpu_rd)
      begin
         record_page = 1'b1;
         case (acf)
            kt11_pkg::acf_nonres:
            begin
               signal_abort = 1'b1;
               flag_nonres  = 1'b1;
               flag_ple     = pg_len_err;
            end
            kt11_pkg::acf_read_write:
            begin
               signal_trap = 1'b1;
               flag_nonres = 1'b1;
               pdr_update  = 1'b1;
               set_a       = 1'b1;
            end
            kt11_pkg::acf_read_only, kt11_pkg::acf_rw_ok:
            begin
               signal_abort = pg_len_err;
               flag_ple     = pg_len_err;
            end
            default: ;
         endcase
      end
   end

   // an access either aborts or traps, never both
   abort_trap_excl: assert final (!(signal_abort && signal_trap));

endmodule

/* hdl/addr_relocator.sv */
// ==================================================
// KT-11 address relocator
// virtual to physical address, I/O page folding
// ==================================================
`timescale 1ns/1ps

module addr_relocator #(
   parameter bit map_22bit = 1'b0
) (
   input  logic [kt11_pkg::va_width-1:0] cpu_va,
   input  logic                          cpu_d_access,
   input  logic [15:0]                   lookup_par,
   input  logic                          mmu_on,
   input  logic                          maint_mode,
   output logic [kt11_pkg::pa_width-1:0] cpu_pa
);

   logic                          map_address;
   logic                          pa_is_iopage;
   logic [kt11_pkg::pa_width-1:0] map_sum;
   logic [kt11_pkg::pa_width-1:0] map_cut;
   logic [kt11_pkg::pa_width-1:0] mapped_pa;
   logic [kt11_pkg::pa_width-1:0] unmapped_pa;

   // maint mode maps destination accesses only
   assign map_address = mmu_on || (maint_mode && cpu_d_access);

   // par counts 64 byte blocks
   assign map_sum = {lookup_par, 6'b000000} + {9'b0, cpu_va[12:0]};
   assign map_cut = map_22bit ? map_sum : {4'b0000, map_sum[17:0]};

   // top 8k of the 18 bit space is the I/O page
   assign pa_is_iopage = !map_22bit && (map_cut[17:13] == 5'b11111);
   assign mapped_pa    = pa_is_iopage ? {6'o77, map_cut[15:0]} : map_cut;

   assign unmapped_pa = (cpu_va[15:13] == 3'b111) ? {6'o77, cpu_va} : {6'o00, cpu_va};

   assign cpu_pa = map_address ? mapped_pa : unmapped_pa;

endmodule

/* hdl/page_reg_file.sv */
// ==================================================
// KT-11 page register file
// 64 PAR/PDR pairs, host port, lookup, A/W updates
// ==================================================
`timescale 1ns/1ps

module page_reg_file (
   input  logic        clk,
   input  logic        local_reset,
   input  logic        pxr_wr,
   input  logic        pxr_rd,
   input  logic [1:0]  pxr_be,
   input  logic [7:0]  pxr_addr,
   input  logic [15:0] pxr_data_in,
   input  logic [5:0]  page_index,
   input  logic        pdr_update,
   input  logic        set_a,
   input  logic        set_w,
   output logic [15:0] lookup_par,
   output logic [15:0] lookup_pdr,
   output logic [15:0] host_read_data
);

   logic [7:0]  par_h [64];
   logic [7:0]  par_l [64];
   logic [7:0]  pdr_h [64];
   logic [7:0]  pdr_l [64];

   logic [5:0]  host_index;
   logic        par_wr;
   logic        pdr_wr;
   logic [15:0] pdr_new;

   // pxr_addr[7] set means an mmr, handled in the status block
   assign host_index = pxr_addr[5:0];
   assign par_wr     = pxr_wr && !pxr_addr[7] && pxr_addr[6];
   assign pdr_wr     = pxr_wr && !pxr_addr[7] && !pxr_addr[6];

   // index is {mode, d, apf}
   assign lookup_par = {par_h[page_index], par_l[page_index]} & kt11_pkg::par_mask;
   assign lookup_pdr = {pdr_h[page_index], pdr_l[page_index]} & kt11_pkg::pdr_read_mask;

   assign host_read_data = pxr_addr[6] ?
      ({par_h[host_index], par_l[host_index]} & kt11_pkg::par_mask) :
      ({pdr_h[host_index], pdr_l[host_index]} & kt11_pkg::pdr_read_mask);

   // A is bit 7, W is bit 6
   assign pdr_new = lookup_pdr | {8'h00, set_a, set_w, 6'b000000};

   always_ff @(posedge clk)
   begin
      if (pxr_wr)
      begin
         if (par_wr && pxr_be[1])
            par_h[host_index] <= pxr_data_in[15:8];
         if (par_wr && pxr_be[0])
            par_l[host_index] <= pxr_data_in[7:0];
         // low byte write drops A and W
         if (pdr_wr && pxr_be[1])
            pdr_h[host_index] <= pxr_data_in[15:8] & kt11_pkg::pdr_write_mask_hi;
         if (pdr_wr && pxr_be[0])
            pdr_l[host_index] <= pxr_data_in[7:0] & kt11_pkg::pdr_write_mask_lo;
      end
      else if (pdr_update)
      begin
         pdr_h[page_index] <= pdr_new[15:8];
         pdr_l[page_index] <= pdr_new[7:0];
      end
   end

   // host side never reads and writes in one cycle
   host_rd_wr_excl: assert property (@(posedge clk) disable iff (local_reset)
      !(pxr_wr && pxr_rd));

endmodule

/* hdl/kt11_pkg.sv */
// ==================================================
// KT-11 MMU shared definitions
// widths, mode and access codes, masks, mmr0 fields
// ==================================================
package kt11_pkg;

   localparam int va_width = 16;
   localparam int pa_width = 22;

   // cpu modes, code 2'b10 is unused
   localparam logic [1:0] mode_kernel = 2'b00;
   localparam logic [1:0] mode_super  = 2'b01;
   localparam logic [1:0] mode_user   = 2'b11;

   // stored access-control codes, bit 0 never survives a write
   localparam logic [2:0] acf_nonres     = 3'd0;
   localparam logic [2:0] acf_read_only  = 3'd2;
   localparam logic [2:0] acf_read_write = 3'd4;
   localparam logic [2:0] acf_rw_ok      = 3'd6;

   // pdr readable bits: plf, A, W, ed, acf
   localparam logic [15:0] pdr_read_mask = 16'o077716;

   // host writable pdr bits per byte
   localparam logic [7:0] pdr_write_mask_hi = 8'o177;
   localparam logic [7:0] pdr_write_mask_lo = 8'o016;

   // 12 bit page address field
   localparam logic [15:0] par_mask = 16'o007777;

   // mmr0 bit positions
   localparam int mmr0_nonres  = 15;
   localparam int mmr0_ple     = 14;
   localparam int mmr0_ro      = 13;
   localparam int mmr0_maint   = 8;
   localparam int mmr0_mode_hi = 6;
   localparam int mmr0_mode_lo = 5;
   localparam int mmr0_page_hi = 3;
   localparam int mmr0_page_lo = 1;
   localparam int mmr0_enable  = 0;

endpackage
